// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = cached_memory_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== include/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// front-end word address, in words
`define ADDR_W 10

`define DATA_W 32
`define NBYTES (`DATA_W / 8)

// 16 lines of 4 words
`define INDEX_W 4
`define OFFSET_W 2
`define TAG_W (`ADDR_W - `INDEX_W - `OFFSET_W)

// backend covers the whole front-end space
`define RAM_DEPTH 1024

`endif

// ==== source/backend_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module backend_ram
   import bus_pkg::*;
(
   input  wire        clk,
   input  wire        rst_n,
   input  wire        req,
   input  word_addr_t addr,
   input  data_t      wdata,
   input  strobe_t    wstrb,
   output data_t      rdata,
   output logic       ack
);

   data_t mem [`RAM_DEPTH];

   // memory starts cleared
   initial begin
      for (int i = 0; i < `RAM_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (req) begin
         if (|wstrb) begin
            for (int b = 0; b < `NBYTES; b++) begin
               if (wstrb[b]) mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
            end
         end else begin
            rdata <= mem[addr];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack <= 1'b0;
      end else begin
         ack <= req;
      end
   end

endmodule

`default_nettype wire

// ==== source/bus_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package bus_pkg;

   // word address, shared by front-end and backend
   typedef logic [`ADDR_W-1:0] word_addr_t;

   typedef logic [`DATA_W-1:0] data_t;

   // all zero means read
   typedef logic [`NBYTES-1:0] strobe_t;

endpackage

`default_nettype wire

// ==== source/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_ctrl
   import bus_pkg::*;
   import cache_pkg::*;
(
   input  wire        clk,
   input  wire        rst_n,
   input  wire        req,
   input  word_addr_t addr,
   input  data_t      wdata,
   input  strobe_t    wstrb,
   output logic       ack,
   output data_t      rdata,
   input  wire        hit,
   output tag_t       lookup_tag,
   output index_t     lookup_index,
   output offset_t    data_offset,
   input  data_t      line_rdata,
   input  offset_t    fill_offset,
   input  wire        fill_last,
   output logic       fill_start,
   output logic       fill_we,
   output logic       fill_tag_we,
   output logic       hit_we,
   output logic       be_req,
   output word_addr_t be_addr,
   output data_t      be_wdata,
   output strobe_t    be_wstrb,
   input  wire        be_ack,
   input  data_t      be_rdata
);

   ctrl_state_t state;
   ctrl_state_t state_nxt;

   word_addr_t addr_q;
   data_t      wdata_q;
   strobe_t    wstrb_q;
   logic       is_write;
   logic       refilling;

   assign is_write  = |wstrb_q;
   assign refilling = (state == st_refill_req) || (state == st_refill_wait);

   // request captured once, held until respond
   always_ff @(posedge clk) begin
      if (state == st_idle && req) begin
         addr_q  <= addr;
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle:        if (req) state_nxt = st_lookup;
         st_lookup: begin
            if (is_write) begin
               state_nxt = st_write_req;
            end else if (hit) begin
               state_nxt = st_respond;
            end else begin
               state_nxt = st_refill_req;
            end
         end
         st_refill_req:  state_nxt = st_refill_wait;
         st_refill_wait: begin
            if (be_ack) state_nxt = fill_last ? st_respond : st_refill_req;
         end
         st_write_req:   state_nxt = st_write_wait;
         st_write_wait:  if (be_ack) state_nxt = st_respond;
         default:        state_nxt = st_idle;
      endcase
   end

   assign lookup_tag   = addr_q[`ADDR_W-1 -: `TAG_W];
   assign lookup_index = addr_q[`OFFSET_W +: `INDEX_W];

   // refill words land at the counter offset, everything else at the request offset
   assign data_offset = (state == st_refill_wait) ? fill_offset : addr_q[`OFFSET_W-1:0];

   assign fill_start  = (state == st_lookup) && !is_write && !hit;
   assign hit_we      = (state == st_lookup) && is_write && hit;
   assign fill_we     = (state == st_refill_wait) && be_ack;
   assign fill_tag_we = fill_we && fill_last;

   assign be_req   = (state == st_refill_req) || (state == st_write_req);
   assign be_addr  = refilling ? {lookup_tag, lookup_index, fill_offset} : addr_q;
   // be_wdata also feeds the data store, so it carries the refill word while be_req is low
   assign be_wdata = (state == st_refill_wait) ? be_rdata : wdata_q;
   assign be_wstrb = wstrb_q;

   assign ack   = (state == st_respond);
   assign rdata = line_rdata;

endmodule

`default_nettype wire

// ==== source/cache_data_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_data_store
   import bus_pkg::*;
   import cache_pkg::*;
(
   input  wire     clk,
   input  index_t  index,
   input  offset_t offset,
   input  wire     fill_we,
   input  wire     hit_we,
   input  data_t   wdata,
   input  strobe_t wstrb,
   output data_t   rdata
);

   localparam int NWORDS = 2 ** (`INDEX_W + `OFFSET_W);

   data_t mem [NWORDS];

   always_ff @(posedge clk) begin
      if (fill_we) begin
         mem[{index, offset}] <= wdata;
      end else if (hit_we) begin
         // merge only the strobed bytes
         for (int b = 0; b < `NBYTES; b++) begin
            if (wstrb[b]) begin
               mem[{index, offset}][b*8 +: 8] <= wdata[b*8 +: 8];
            end
         end
      end
   end

   assign rdata = mem[{index, offset}];

endmodule

`default_nettype wire

// ==== source/cache_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

   typedef logic [`TAG_W-1:0]    tag_t;
   typedef logic [`INDEX_W-1:0]  index_t;
   typedef logic [`OFFSET_W-1:0] offset_t;

   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_refill_req,
      st_refill_wait,
      st_write_req,
      st_write_wait,
      st_respond
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/cache_tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_tag_store
   import cache_pkg::*;
(
   input  wire    clk,
   input  wire    rst_n,
   input  index_t index,
   input  tag_t   tag,
   input  wire    tag_we,
   input  wire    invalidate,
   output logic   hit
);

   localparam int NLINES = 2 ** `INDEX_W;

   logic [NLINES-1:0] valid;
   tag_t              tags [NLINES];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid <= '0;
      end else if (invalidate) begin
         valid <= '0;
      end else if (tag_we) begin
         valid[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (tag_we) begin
         tags[index] <= tag;
      end
   end

   assign hit = valid[index] && (tags[index] == tag);

endmodule

`default_nettype wire

// ==== source/cached_memory_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cached_memory_top
   import bus_pkg::*;
   import cache_pkg::*;
(
   input  wire        clk,
   input  wire        rst_n,
   input  wire        req,
   input  word_addr_t addr,
   input  data_t      wdata,
   input  strobe_t    wstrb,
   input  wire        invalidate,
   output data_t      rdata,
   output logic       ack
);

   logic       hit;
   tag_t       lookup_tag;
   index_t     lookup_index;
   offset_t    data_offset;
   data_t      line_rdata;
   offset_t    fill_offset;
   logic       fill_last;
   logic       fill_start;
   logic       fill_we;
   logic       fill_tag_we;
   logic       hit_we;

   // backend side
   logic       be_req;
   word_addr_t be_addr;
   data_t      be_wdata;
   strobe_t    be_wstrb;
   logic       be_ack;
   data_t      be_rdata;

   cache_ctrl ctrl_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (req),
      .addr         (addr),
      .wdata        (wdata),
      .wstrb        (wstrb),
      .ack          (ack),
      .rdata        (rdata),
      .hit          (hit),
      .lookup_tag   (lookup_tag),
      .lookup_index (lookup_index),
      .data_offset  (data_offset),
      .line_rdata   (line_rdata),
      .fill_offset  (fill_offset),
      .fill_last    (fill_last),
      .fill_start   (fill_start),
      .fill_we      (fill_we),
      .fill_tag_we  (fill_tag_we),
      .hit_we       (hit_we),
      .be_req       (be_req),
      .be_addr      (be_addr),
      .be_wdata     (be_wdata),
      .be_wstrb     (be_wstrb),
      .be_ack       (be_ack),
      .be_rdata     (be_rdata)
   );

   // one step per refill word written
   line_fill_counter fill_cnt_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .start  (fill_start),
      .step   (fill_we),
      .offset (fill_offset),
      .last   (fill_last)
   );

   cache_tag_store tag_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .index      (lookup_index),
      .tag        (lookup_tag),
      .tag_we     (fill_tag_we),
      .invalidate (invalidate),
      .hit        (hit)
   );

   cache_data_store data_i (
      .clk     (clk),
      .index   (lookup_index),
      .offset  (data_offset),
      .fill_we (fill_we),
      .hit_we  (hit_we),
      .wdata   (be_wdata),
      .wstrb   (be_wstrb),
      .rdata   (line_rdata)
   );

   backend_ram ram_i (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (be_req),
      .addr  (be_addr),
      .wdata (be_wdata),
      .wstrb (be_wstrb),
      .rdata (be_rdata),
      .ack   (be_ack)
   );

endmodule

`default_nettype wire

// ==== source/line_fill_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_fill_counter
   import cache_pkg::*;
(
   input  wire     clk,
   input  wire     rst_n,
   input  wire     start,
   input  wire     step,
   output offset_t offset,
   output logic    last
);

   // wraps to zero after the final word
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         offset <= '0;
      end else if (start) begin
         offset <= '0;
      end else if (step) begin
         offset <= offset + 1'b1;
      end
   end

   assign last = &offset;

endmodule

`default_nettype wire

// ==== tests/cached_memory_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cached_memory_tb
   import bus_pkg::*;
();

   localparam int N_DIRECTED = 20;
   localparam int N_RANDOM   = 200;
   // a full refill takes well under 20 cycles
   localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 20 + 200;

   localparam int LAT_ANY  = 0;
   localparam int LAT_HIT  = 1;
   localparam int LAT_MISS = 2;

   logic       clk;
   logic       rst_n;
   logic       req;
   word_addr_t addr;
   data_t      wdata;
   strobe_t    wstrb;
   logic       invalidate;
   data_t      rdata;
   logic       ack;

   // expected backend contents
   data_t shadow [`RAM_DEPTH];

   int checks;
   int errors;
   int requests;

   cached_memory_top dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .addr       (addr),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .invalidate (invalidate),
      .rdata      (rdata),
      .ack        (ack)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic data_t merge_bytes(data_t old_word, data_t new_word, strobe_t strb);
      data_t result;
      result = old_word;
      for (int b = 0; b < `NBYTES; b++) begin
         if (strb[b]) result[b*8 +: 8] = new_word[b*8 +: 8];
      end
      return result;
   endfunction

   // few tags on two indexes, so lines keep evicting each other
   function automatic word_addr_t random_addr();
      logic [1:0]           tag_low;
      logic                 index_low;
      logic [`OFFSET_W-1:0] offset;
      tag_low   = 2'($urandom);
      index_low = 1'($urandom);
      offset    = `OFFSET_W'($urandom);
      return {{(`TAG_W-2){1'b0}}, tag_low, {(`INDEX_W-1){1'b0}}, index_low, offset};
   endfunction

   // one request, latency counted in rising edges from the drive edge to ack
   task automatic bus_access(input word_addr_t a, input data_t d, input strobe_t s,
                             output data_t rd, output int lat);
      lat = 0;
      @(posedge clk);
      req   <= 1'b1;
      addr  <= a;
      wdata <= d;
      wstrb <= s;
      requests++;
      @(negedge clk);
      while (!ack) begin
         lat++;
         @(negedge clk);
      end
      rd = rdata;
      @(posedge clk);
      req   <= 1'b0;
      wstrb <= '0;
      @(negedge clk);
      checks++;
      assert (!ack) else begin
         errors++;
         $display("** Error at %0t: ack got %b, expected %b one cycle after ack",
                  $time, ack, 1'b0);
      end
   endtask

   task automatic read_check(input word_addr_t a, input int mode);
      data_t rd;
      int    lat;
      bus_access(a, '0, '0, rd, lat);
      checks++;
      assert (rd == shadow[a]) else begin
         errors++;
         $display("** Error at %0t: rdata got %h, expected %h at addr %h",
                  $time, rd, shadow[a], a);
      end
      if (mode == LAT_HIT) begin
         checks++;
         assert (lat == 2) else begin
            errors++;
            $display("** Error at %0t: read ack latency got %0d, expected 2", $time, lat);
         end
      end else if (mode == LAT_MISS) begin
         checks++;
         assert (lat > 2) else begin
            errors++;
            $display("** Error at %0t: read ack latency got %0d, expected more than 2",
                     $time, lat);
         end
      end
   endtask

   task automatic write_check(input word_addr_t a, input data_t d, input strobe_t s);
      data_t rd;
      int    lat;
      bus_access(a, d, s, rd, lat);
      shadow[a] = merge_bytes(shadow[a], d, s);
      checks++;
      assert (lat == 4) else begin
         errors++;
         $display("** Error at %0t: write ack latency got %0d, expected 4", $time, lat);
      end
   endtask

   task automatic pulse_invalidate();
      @(posedge clk);
      invalidate <= 1'b1;
      @(posedge clk);
      invalidate <= 1'b0;
   endtask

   initial begin
      word_addr_t a;
      $timeformat(-9, 0, " ns", 0);
      void'($urandom(18));
      checks     = 0;
      errors     = 0;
      requests   = 0;
      rst_n      = 1'b0;
      req        = 1'b0;
      addr       = '0;
      wdata      = '0;
      wstrb      = '0;
      invalidate = 1'b0;
      for (int i = 0; i < `RAM_DEPTH; i++) begin
         shadow[i] = '0;
      end

      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      checks++;
      assert (!ack) else begin
         errors++;
         $display("** Error at %0t: ack got %b, expected %b after reset", $time, ack, 1'b0);
      end

      // cold miss, then hits in the same line
      read_check(10'h000, LAT_MISS);
      read_check(10'h002, LAT_HIT);
      read_check(10'h003, LAT_HIT);

      // write hits with full and partial strobes
      write_check(10'h001, 32'h1122_3344, 4'b1111);
      write_check(10'h001, 32'haabb_ccdd, 4'b0101);
      read_check(10'h001, LAT_HIT);

      // write miss does not allocate
      write_check(10'h105, 32'hdead_beef, 4'b0010);
      read_check(10'h105, LAT_MISS);
      read_check(10'h106, LAT_HIT);
      write_check(10'h106, 32'h5566_7788, 4'b1100);
      read_check(10'h106, LAT_HIT);

      pulse_invalidate();
      read_check(10'h001, LAT_MISS);
      read_check(10'h105, LAT_MISS);
      read_check(10'h002, LAT_HIT);

      // same index, other tag
      read_check(10'h041, LAT_MISS);
      read_check(10'h001, LAT_MISS);

      for (int i = 0; i < N_RANDOM; i++) begin
         a = random_addr();
         if ($urandom % 2 == 0) begin
            read_check(a, LAT_ANY);
         end else begin
            write_check(a, data_t'($urandom), strobe_t'($urandom % 15 + 1));
         end
      end

      $display("requests: %0d, checks: %0d, errors: %0d", requests, checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
source/bus_pkg.sv
source/cache_pkg.sv
source/line_fill_counter.sv
source/cache_tag_store.sv
source/cache_data_store.sv
source/backend_ram.sv
source/cache_ctrl.sv
source/cached_memory_top.sv
tests/cached_memory_tb.sv
